// ==== compile.f ====
lg_pkg.sv
lg_regs.sv
lg_table.sv
lg_burst.sv
lg_drive.sv
lg_top.sv
tb_lg.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, decide by the log
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_lg -f compile.f -o tb_lg &&
./obj_dir/tb_lg > sim.log 2>&1
cat sim.log
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb_lg.sv ====
// logic pattern generator testbench
// directed tests of register readback, bursts, triggers, stop,
// back-pressure and the output stage against a model of the burst rule
`timescale 1ns/1ps
`default_nettype none

module tb_lg;

  localparam int unsigned TN = 2;

  // register map, byte addresses
  localparam logic [11:0] A_EVN = 12'h000;
  localparam logic [11:0] A_TRG = 12'h008;
  localparam logic [11:0] A_INF = 12'h010;
  localparam logic [11:0] A_BDR = 12'h020;
  localparam logic [11:0] A_BDL = 12'h024;
  localparam logic [11:0] A_BPL = 12'h028;
  localparam logic [11:0] A_BPN = 12'h02c;
  localparam logic [11:0] A_SPL = 12'h030;
  localparam logic [11:0] A_SPN = 12'h034;
  localparam logic [11:0] A_OE0 = 12'h040;
  localparam logic [11:0] A_OE1 = 12'h044;
  localparam logic [11:0] A_MSK = 12'h048;
  localparam logic [11:0] A_VAL = 12'h04c;

  localparam lg_pkg::evn_t EV_RST = '{rst: 1'b1, str: 1'b0, stp: 1'b0, swt: 1'b0};
  localparam lg_pkg::evn_t EV_STR = '{rst: 1'b0, str: 1'b1, stp: 1'b0, swt: 1'b0};
  localparam lg_pkg::evn_t EV_STP = '{rst: 1'b0, str: 1'b0, stp: 1'b1, swt: 1'b0};
  localparam lg_pkg::evn_t EV_SWT = '{rst: 1'b0, str: 1'b0, stp: 1'b0, swt: 1'b1};

  logic             bus = 1'b0;
  logic             rst_n;
  lg_pkg::bus_req_t reg_req;
  lg_pkg::bus_rsp_t reg_rsp;
  lg_pkg::bus_req_t tbl_req;
  lg_pkg::bus_rsp_t tbl_rsp;
  logic [TN-1:0]    trg;
  lg_pkg::evn_t     evo;
  lg_pkg::trg_t     tro;
  logic             irq;
  lg_pkg::stm_t     sto;
  logic             ready = 1'b1;

  logic             rnd_ready = 1'b0;     // random back-pressure on
  logic [31:0]      lfsr = 32'hb7c9f56d;
  int               n_per = 0;           // tro.per pulses seen
  int               n_lst = 0;           // tro.lst pulses seen
  int               n_irq = 0;           // irq cycles seen
  int               n_err = 0;
  lg_pkg::out_t     got_q[$];            // accepted beats
  lg_pkg::out_t     exp_q[$];            // model beats

  lg_top dut0 (
    .bus     (bus),
    .rst_n   (rst_n),
    .reg_req (reg_req),
    .reg_rsp (reg_rsp),
    .tbl_req (tbl_req),
    .tbl_rsp (tbl_rsp),
    .trg     (trg),
    .evo     (evo),
    .tro     (tro),
    .irq     (irq),
    .sto     (sto),
    .ready   (ready)
  );

  always #2 bus = ~bus;  // 4 ns period

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  always @(negedge bus) begin
    if (rnd_ready) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      ready <= lfsr[0];
    end else begin
      ready <= 1'b1;
    end
  end

  // stream and pulse monitor
  always @(posedge bus) begin
    if (rst_n) begin
      if (sto.valid && ready) got_q.push_back(sto.dat);
      if (tro.per) n_per = n_per + 1;
      if (tro.lst) n_lst = n_lst + 1;
      if (irq)     n_irq = n_irq + 1;
    end
  end

  //////////////////////////////////////////////////
  // checks and bus access
  //////////////////////////////////////////////////

  task automatic fail_run(input string why);
    n_err = n_err + 1;
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("** Error at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp));
    end
  endtask

  // one strobe, ack exactly one cycle later
  task automatic bus_xfer(input bit on_tbl, input bit wr, input logic [11:0] a,
                          input logic [31:0] wd, output logic [31:0] rd);
    lg_pkg::bus_req_t rq;
    lg_pkg::bus_rsp_t rs;
    rq = '{wen: wr, ren: !wr, addr: a, wdata: wd};
    @(negedge bus);
    rs = on_tbl ? tbl_rsp : reg_rsp;
    expect_eq($sformatf("ack before request 0x%03h", a), 32'(rs.ack), 32'd0);
    if (on_tbl) tbl_req = rq;
    else        reg_req = rq;
    @(negedge bus);
    tbl_req = '0;
    reg_req = '0;
    rs = on_tbl ? tbl_rsp : reg_rsp;
    expect_eq($sformatf("ack of request 0x%03h", a), 32'(rs.ack), 32'd1);
    rd = rs.rdata;
  endtask

  task automatic reg_wr(input logic [11:0] a, input logic [31:0] d);
    logic [31:0] unused;
    bus_xfer(1'b0, 1'b1, a, d, unused);
  endtask

  task automatic reg_expect(input logic [11:0] a, input logic [31:0] exp);
    logic [31:0] r;
    bus_xfer(1'b0, 1'b0, a, 32'd0, r);
    expect_eq($sformatf("reg_rsp.rdata 0x%03h", a), r, exp);
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge bus);
  endtask

  task automatic pulse_trg(input logic [TN-1:0] t);
    @(negedge bus);
    trg = t;
    @(negedge bus);
    trg = '0;
  endtask

  //////////////////////////////////////////////////
  // model of table, burst and output rules
  //////////////////////////////////////////////////

  function automatic lg_pkg::dat_t tbl_word(input int a);
    logic [9:0] ad;
    ad = 10'(a);
    return (ad[7:0] * 8'd29) ^ {ad[9:8], ad[9:4]} ^ 8'h3c;  // full address
  endfunction

  task automatic build_model(input int bdr, input int bdl, input int bpl, input int nper,
                             input lg_pkg::dat_t msk, val, oe0, oe1);
    lg_pkg::dat_t d;
    lg_pkg::out_t b;
    int           w;
    exp_q.delete();
    for (int p = 0; p < nper; p++) begin
      for (int k = 0; k <= bpl; k++) begin
        w = k / (bdr + 1);
        if (w > bdl) w = bdl;  // padding repeats last word
        d = tbl_word(w);
        for (int i = 0; i < 8; i++) begin
          b.o[i] = msk[i] ? val[i] : d[i] ^ val[i];  // masked bit shows polarity only
          b.e[i] = b.o[i] ? oe1[i] : oe0[i];
        end
        exp_q.push_back(b);
      end
    end
  endtask

  task automatic set_burst(input int bdr, input int bdl, input int bpl, input int bpn,
                           input bit inf);
    reg_wr(A_BDR, 32'(bdr));
    reg_wr(A_BDL, 32'(bdl));
    reg_wr(A_BPL, 32'(bpl));
    reg_wr(A_BPN, 32'(bpn));
    reg_wr(A_INF, 32'(inf));
  endtask

  task automatic set_out(input lg_pkg::dat_t msk, val, oe0, oe1);
    reg_wr(A_MSK, 32'(msk));
    reg_wr(A_VAL, 32'(val));
    reg_wr(A_OE0, 32'(oe0));
    reg_wr(A_OE1, 32'(oe1));
  endtask

  task automatic wait_beats(input int base, input int n, input int limit);
    int t;
    t = 0;
    while (got_q.size() < base + n) begin
      @(negedge bus);
      t++;
      if (t > limit) fail_run($sformatf("timeout, only %0d of %0d beats accepted",
                                        got_q.size() - base, n));
    end
  endtask

  task automatic check_beats(input int base, input int n);
    for (int i = 0; i < n; i++) begin
      expect_eq($sformatf("sto.dat.o beat %0d", i), 32'(got_q[base+i].o), 32'(exp_q[i].o));
      expect_eq($sformatf("sto.dat.e beat %0d", i), 32'(got_q[base+i].e), 32'(exp_q[i].e));
    end
  endtask

  // trigger an armed generator, compare the whole burst
  task automatic launch_and_check(input bit ext, input int nper, input int limit);
    int base;
    int per0;
    int lst0;
    int irq0;
    int t;
    base = got_q.size();
    per0 = n_per;
    lst0 = n_lst;
    irq0 = n_irq;
    if (ext) pulse_trg(2'b01);
    else     reg_wr(A_EVN, 32'(EV_SWT));
    wait_beats(base, exp_q.size(), limit);
    t = 0;
    while (n_irq == irq0) begin
      @(negedge bus);
      t++;
      if (t > 20) fail_run("timeout waiting for irq after the burst");
    end
    idle(10);  // no extra beats
    expect_eq("accepted beat count", 32'(got_q.size() - base), 32'(exp_q.size()));
    check_beats(base, exp_q.size());
    expect_eq("tro.per pulses", 32'(n_per - per0), 32'(nper));
    expect_eq("tro.lst pulses", 32'(n_lst - lst0), 32'd1);
    expect_eq("irq pulses", 32'(n_irq - irq0), 32'd1);
    reg_expect(A_SPN, 32'(nper));    // periods done
    reg_expect(A_EVN, 32'(EV_STP));  // back to idle
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic regs_readback();
    logic [31:0] r;
    reg_wr(A_TRG, 32'h2);
    reg_expect(A_TRG, 32'h2);
    reg_wr(A_INF, 32'h1);
    reg_expect(A_INF, 32'h1);
    reg_wr(A_BDR, 32'h2a5c);
    reg_expect(A_BDR, 32'h2a5c);
    reg_wr(A_BDL, 32'h2c7);
    reg_expect(A_BDL, 32'h2c7);
    reg_wr(A_BPL, 32'h89abcdef);
    reg_expect(A_BPL, 32'h89abcdef);
    reg_wr(A_BPN, 32'hbeef);
    reg_expect(A_BPN, 32'hbeef);
    set_out(8'h81, 8'h7e, 8'h5a, 8'hc3);
    reg_expect(A_MSK, 32'h81);
    reg_expect(A_VAL, 32'h7e);
    reg_expect(A_OE0, 32'h5a);
    reg_expect(A_OE1, 32'hc3);
    reg_expect(12'h00c, 32'h0);        // unmapped
    reg_expect(A_EVN, 32'(EV_STP));    // idle
    for (int a = 0; a < 16; a++) begin
      bus_xfer(1'b1, 1'b1, 12'(a * 4), 32'(tbl_word(a)), r);
    end
    for (int a = 0; a < 16; a++) begin
      bus_xfer(1'b1, 1'b0, 12'(a * 4), 32'd0, r);
      expect_eq($sformatf("tbl_rsp.rdata word %0d", a), r, 32'(tbl_word(a)));
    end
    reg_wr(A_TRG, 32'h0);
    reg_wr(A_INF, 32'h0);
  endtask

  task automatic single_burst();
    set_burst(1, 3, 11, 1, 1'b0);
    set_out(8'h00, 8'h00, 8'h00, 8'h00);
    build_model(1, 3, 11, 2, 8'h00, 8'h00, 8'h00, 8'h00);
    reg_wr(A_EVN, 32'(EV_STR));
    expect_eq("evo", 32'(evo), 32'(EV_STR));  // copy one cycle after write
    launch_and_check(1'b0, 2, 200);
  endtask

  task automatic backpressure_burst();
    rnd_ready = 1'b1;
    reg_wr(A_EVN, 32'(EV_STR));
    launch_and_check(1'b0, 2, 1000);
    rnd_ready = 1'b0;
  endtask

  task automatic trigger_mask();
    int base;
    set_burst(0, 2, 4, 0, 1'b0);
    build_model(0, 2, 4, 1, 8'h00, 8'h00, 8'h00, 8'h00);
    reg_wr(A_TRG, 32'h2);  // bit 0 masked off
    reg_wr(A_EVN, 32'(EV_STR));
    base = got_q.size();
    pulse_trg(2'b01);
    idle(10);
    expect_eq("beats with masked trigger", 32'(got_q.size() - base), 32'd0);
    reg_expect(A_EVN, 32'(EV_STR));  // still armed
    reg_wr(A_TRG, 32'h3);
    launch_and_check(1'b1, 1, 100);
    base = got_q.size();
    pulse_trg(2'b01);  // not armed now
    idle(10);
    expect_eq("beats while not armed", 32'(got_q.size() - base), 32'd0);
    reg_wr(A_TRG, 32'h0);
  endtask

  task automatic stop_infinite();
    int base;
    int irq0;
    int t;
    set_burst(1, 1, 5, 0, 1'b1);
    build_model(1, 1, 5, 8, 8'h00, 8'h00, 8'h00, 8'h00);
    base = got_q.size();
    irq0 = n_irq;
    reg_wr(A_EVN, 32'(EV_STR));
    reg_wr(A_EVN, 32'(EV_SWT));
    wait_beats(base, 30, 200);  // past several periods
    reg_wr(A_EVN, 32'(EV_STP));
    t = 0;
    while (sto.valid) begin
      @(negedge bus);
      t++;
      if (t > 3) fail_run("stream still valid more than 3 cycles after stop");
    end
    idle(10);
    expect_eq("sto.valid after stop", 32'(sto.valid), 32'd0);
    if (got_q.size() - base > exp_q.size()) fail_run("more beats than the model allows");
    check_beats(base, got_q.size() - base);
    expect_eq("irq pulses after stop", 32'(n_irq - irq0), 32'd0);
    reg_expect(A_EVN, 32'(EV_STP));
    reg_wr(A_EVN, 32'(EV_RST));  // counters cleared
    reg_expect(A_SPL, 32'd0);
    reg_expect(A_SPN, 32'd0);
    reg_wr(A_INF, 32'h0);
  endtask

  task automatic output_stage();
    set_burst(2, 4, 16, 1, 1'b0);
    set_out(8'hf0, 8'h5a, 8'h33, 8'hcc);
    build_model(2, 4, 16, 2, 8'hf0, 8'h5a, 8'h33, 8'hcc);
    reg_wr(A_EVN, 32'(EV_STR));
    launch_and_check(1'b0, 2, 200);
  endtask

  initial begin
    rst_n   = 1'b0;
    reg_req = '0;
    tbl_req = '0;
    trg     = '0;
    repeat (5) @(negedge bus);
    rst_n = 1'b1;
    expect_eq("outputs after reset",
              32'({sto.valid, tro, irq, evo, reg_rsp.ack, tbl_rsp.ack}), 32'd0);
    regs_readback();
    single_burst();
    backpressure_burst();
    trigger_mask();
    stop_infinite();
    output_stage();
    idle(2);
    if (n_err == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // last resort if a wait never returns
  initial begin
    #1ms;
    fail_run("global timeout, simulation did not finish");
  end

endmodule

`default_nettype wire

// ==== lg_top.sv ====
// logic pattern generator top level
// register block, waveform table, burst sequencer and output stage
`timescale 1ns/1ps
`default_nettype none

module lg_top #(
  parameter int unsigned AW  = 10,
  parameter int unsigned CWR = 14,
  parameter int unsigned CWL = 32,
  parameter int unsigned CWN = 16,
  parameter int unsigned TN  = 2
) (
  input  logic             bus,
  input  logic             rst_n,
  input  lg_pkg::bus_req_t reg_req,  // register bus
  output lg_pkg::bus_rsp_t reg_rsp,
  input  lg_pkg::bus_req_t tbl_req,  // table bus
  output lg_pkg::bus_rsp_t tbl_rsp,
  input  logic [TN-1:0]    trg,
  output lg_pkg::evn_t     evo,
  output lg_pkg::trg_t     tro,
  output logic             irq,
  output lg_pkg::stm_t     sto,
  input  logic             ready
);

  // configuration levels
  logic           cfg_inf;
  logic [CWR-1:0] cfg_bdr;
  logic [AW-1:0]  cfg_bdl;
  logic [CWL-1:0] cfg_bpl;
  logic [CWN-1:0] cfg_bpn;
  lg_pkg::dat_t   cfg_oe0;
  lg_pkg::dat_t   cfg_oe1;
  lg_pkg::dat_t   cfg_msk;
  lg_pkg::dat_t   cfg_val;
  // control and status
  lg_pkg::evn_t   ctl;
  logic           ctl_trg;
  logic [CWL-1:0] sts_bpl;
  logic [CWN-1:0] sts_bpn;
  logic [1:0]     sts_run;
  // table read, generator stream
  logic           rd_en;
  logic [AW-1:0]  rd_addr;
  lg_pkg::dat_t   rd_data;
  lg_pkg::stm_t   stg;
  logic           stall;

  lg_regs #(.AW(AW), .CWR(CWR), .CWL(CWL), .CWN(CWN), .TN(TN)) regs0 (
    .bus     (bus),
    .rst_n   (rst_n),
    .reg_req (reg_req),
    .reg_rsp (reg_rsp),
    .trg     (trg),
    .sts_bpl (sts_bpl),
    .sts_bpn (sts_bpn),
    .sts_run (sts_run),
    .irq_src (tro.lst),
    .cfg_inf (cfg_inf),
    .cfg_bdr (cfg_bdr),
    .cfg_bdl (cfg_bdl),
    .cfg_bpl (cfg_bpl),
    .cfg_bpn (cfg_bpn),
    .cfg_oe0 (cfg_oe0),
    .cfg_oe1 (cfg_oe1),
    .cfg_msk (cfg_msk),
    .cfg_val (cfg_val),
    .ctl     (ctl),
    .ctl_trg (ctl_trg),
    .evo     (evo),
    .irq     (irq)
  );

  lg_table #(.AW(AW)) table0 (
    .bus     (bus),
    .rst_n   (rst_n),
    .tbl_req (tbl_req),
    .tbl_rsp (tbl_rsp),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  lg_burst #(.AW(AW), .CWR(CWR), .CWL(CWL), .CWN(CWN)) burst0 (
    .bus     (bus),
    .rst_n   (rst_n),
    .ctl     (ctl),
    .ctl_trg (ctl_trg),
    .cfg_bdr (cfg_bdr),
    .cfg_bdl (cfg_bdl),
    .cfg_bpl (cfg_bpl),
    .cfg_bpn (cfg_bpn),
    .cfg_inf (cfg_inf),
    .stall   (stall),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .stm     (stg),
    .tro     (tro),
    .sts_bpl (sts_bpl),
    .sts_bpn (sts_bpn),
    .sts_run (sts_run)
  );

  lg_drive drive0 (
    .bus     (bus),
    .rst_n   (rst_n),
    .stm_in  (stg),
    .stall   (stall),
    .cfg_oe0 (cfg_oe0),
    .cfg_oe1 (cfg_oe1),
    .cfg_msk (cfg_msk),
    .cfg_val (cfg_val),
    .sto     (sto),
    .ready   (ready)
  );

endmodule

`default_nettype wire

// ==== lg_drive.sv ====
// output stage
// applies mask and polarity, derives per-bit enable, holds the beat until ready
`timescale 1ns/1ps
`default_nettype none

module lg_drive (
  input  logic         bus,
  input  logic         rst_n,
  input  lg_pkg::stm_t stm_in,
  output logic         stall,
  input  lg_pkg::dat_t cfg_oe0,  // enable where o is 0
  input  lg_pkg::dat_t cfg_oe1,  // enable where o is 1
  input  lg_pkg::dat_t cfg_msk,
  input  lg_pkg::dat_t cfg_val,
  output lg_pkg::stm_t sto,
  input  logic         ready
);

  lg_pkg::dat_t o_nxt;
  lg_pkg::out_t dat_q;
  logic         vld_q;

  // masked bits take the polarity value only
  assign o_nxt = cfg_val ^ (stm_in.dat.o & ~cfg_msk);

  assign stall = vld_q & ~ready;  // beat held, not taken

  always_ff @(posedge bus) begin
    if (!rst_n)      vld_q <= 1'b0;
    else if (!stall) vld_q <= stm_in.valid;
  end

  always_ff @(posedge bus) begin
    if (!stall) begin
      dat_q.o <= o_nxt;
      dat_q.e <= (cfg_oe1 & o_nxt) | (cfg_oe0 & ~o_nxt);
    end
  end

  assign sto = '{valid: vld_q, dat: dat_q};

  // valid beat stays until accepted
  a_hold: assert property (@(posedge bus) disable iff (!rst_n)
    sto.valid && !ready |=> sto.valid && $stable(sto.dat));

endmodule

`default_nettype wire

// ==== lg_burst.sv ====
// burst sequencer
// idle/armed/run FSM, nested repeat, data, period beat and period counters,
// table address stage and valid pipeline matched to table latency
`timescale 1ns/1ps
`default_nettype none

module lg_burst #(
  parameter int unsigned AW  = 10,
  parameter int unsigned CWR = 14,
  parameter int unsigned CWL = 32,
  parameter int unsigned CWN = 16
) (
  input  logic           bus,
  input  logic           rst_n,
  input  lg_pkg::evn_t   ctl,
  input  logic           ctl_trg,
  input  logic [CWR-1:0] cfg_bdr,
  input  logic [AW-1:0]  cfg_bdl,
  input  logic [CWL-1:0] cfg_bpl,
  input  logic [CWN-1:0] cfg_bpn,
  input  logic           cfg_inf,
  input  logic           stall,    // freezes the whole pipeline
  output logic           rd_en,
  output logic [AW-1:0]  rd_addr,
  input  lg_pkg::dat_t   rd_data,  // one cycle after rd_addr
  output lg_pkg::stm_t   stm,
  output lg_pkg::trg_t   tro,
  output logic [CWL-1:0] sts_bpl,
  output logic [CWN-1:0] sts_bpn,
  output logic [1:0]     sts_run   // {busy, armed}
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARMED,
    ST_RUN
  } st_t;

  st_t            st;
  logic [CWR-1:0] cnt_rep;  // repeat of current word
  logic [AW-1:0]  cnt_idx;  // table word index
  logic           dat_end;  // data part of period done
  logic [CWL-1:0] cnt_bpl;  // beat in period
  logic [CWN-1:0] cnt_bpn;  // period number
  logic           launch;
  logic           abort;
  logic           clr;
  logic           issue;    // beat enters address stage
  logic           per_end;
  logic           bst_end;
  logic           v_adr;    // address stage valid
  logic           v_dat;    // table data stage valid

  assign launch  = (st == ST_ARMED) & ctl_trg;
  assign abort   = ctl.stp | ctl.rst;
  assign clr     = ctl.rst | (ctl.str & (st == ST_IDLE));
  assign issue   = ~stall & ~abort & ((st == ST_RUN) | launch);
  assign per_end = (cnt_bpl == cfg_bpl);
  assign bst_end = per_end & ~cfg_inf & (cnt_bpn == cfg_bpn);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      st <= ST_IDLE;
    end else if (abort) begin
      st <= ST_IDLE;                      // stop disarms
    end else if (issue && bst_end) begin
      st <= ST_IDLE;                      // burst done
    end else if (launch) begin
      st <= ST_RUN;                       // also taken under stall
    end else if (ctl.str && st == ST_IDLE) begin
      st <= ST_ARMED;
    end
  end

  //////////////////////////////////////////////////
  // counters, advance once per issued beat
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n || clr) begin
      cnt_rep <= '0;
      cnt_idx <= '0;
      dat_end <= 1'b0;
      cnt_bpl <= '0;
      cnt_bpn <= '0;
    end else if (issue) begin
      if (per_end) begin
        // next period restarts the data
        cnt_rep <= '0;
        cnt_idx <= '0;
        dat_end <= 1'b0;
        cnt_bpl <= '0;
        cnt_bpn <= cnt_bpn + 1'b1;
      end else begin
        cnt_bpl <= cnt_bpl + 1'b1;
        if (!dat_end) begin
          if (cnt_rep == cfg_bdr) begin
            cnt_rep <= '0;
            if (cnt_idx == cfg_bdl) dat_end <= 1'b1;  // pad with last word
            else                    cnt_idx <= cnt_idx + 1'b1;
          end else begin
            cnt_rep <= cnt_rep + 1'b1;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // address / data pipeline
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      v_adr <= 1'b0;
      v_dat <= 1'b0;
    end else if (!stall) begin
      v_adr <= issue;
      v_dat <= v_adr;
    end
  end

  always_ff @(posedge bus) begin
    if (issue) rd_addr <= cnt_idx;
  end

  assign rd_en = v_adr & ~stall;

  // enable is formed in the output stage
  assign stm = '{valid: v_dat, dat: '{o: rd_data, e: '0}};

  // period pulses, aligned with the address stage
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      tro <= '0;
    end else begin
      tro.per <= issue & (cnt_bpl == '0);
      tro.lst <= issue & bst_end;
    end
  end

  assign sts_bpl = cnt_bpl;
  assign sts_bpn = cnt_bpn;
  assign sts_run = {st == ST_RUN, st == ST_ARMED};

  // stall holds the beat offered to the output stage
  a_stall_hold: assert property (@(posedge bus) disable iff (!rst_n)
    stall |=> $stable(stm));

  // burst is over once the last pulse shows, nothing more issued
  a_lst_run: assert property (@(posedge bus) disable iff (!rst_n)
    tro.lst |-> sts_run == 2'b00 && !issue);

endmodule

`default_nettype wire

// ==== lg_table.sv ====
// waveform table
// CPU write/read port on word addresses, registered generator read port
`timescale 1ns/1ps
`default_nettype none

module lg_table #(
  parameter int unsigned AW = 10
) (
  input  logic             bus,
  input  logic             rst_n,
  input  lg_pkg::bus_req_t tbl_req,
  output lg_pkg::bus_rsp_t tbl_rsp,
  input  logic             rd_en,    // low holds rd_data
  input  logic [AW-1:0]    rd_addr,
  output lg_pkg::dat_t     rd_data
);

  lg_pkg::dat_t           mem [2**AW];
  logic [AW-1:0]          cpu_adr;
  logic                   ack_q;
  logic [lg_pkg::BDW-1:0] rdata_q;

  assign cpu_adr = tbl_req.addr[AW+1:2];  // byte to word address

  //////////////////////////////////////////////////
  // CPU port
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (tbl_req.wen) mem[cpu_adr] <= tbl_req.wdata[lg_pkg::DW-1:0];
    if (tbl_req.ren) rdata_q <= 32'(mem[cpu_adr]);  // zero extended
  end

  always_ff @(posedge bus) begin
    if (!rst_n) ack_q <= 1'b0;
    else        ack_q <= tbl_req.wen | tbl_req.ren;
  end

  assign tbl_rsp = '{ack: ack_q, rdata: rdata_q};

  //////////////////////////////////////////////////
  // generator port
  //////////////////////////////////////////////////

  // held during stall
  always_ff @(posedge bus) begin
    if (rd_en) rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== lg_regs.sv ====
// logic generator register block
// config registers, status readback, software events,
// trigger masking and the interrupt register
`timescale 1ns/1ps
`default_nettype none

module lg_regs #(
  parameter int unsigned AW  = 10,
  parameter int unsigned CWR = 14,
  parameter int unsigned CWL = 32,
  parameter int unsigned CWN = 16,
  parameter int unsigned TN  = 2
) (
  input  logic             bus,
  input  logic             rst_n,
  input  lg_pkg::bus_req_t reg_req,
  output lg_pkg::bus_rsp_t reg_rsp,
  input  logic [TN-1:0]    trg,      // external triggers, raw
  input  logic [CWL-1:0]   sts_bpl,
  input  logic [CWN-1:0]   sts_bpn,
  input  logic [1:0]       sts_run,  // {busy, armed}
  input  logic             irq_src,  // last period pulse
  output logic             cfg_inf,
  output logic [CWR-1:0]   cfg_bdr,
  output logic [AW-1:0]    cfg_bdl,
  output logic [CWL-1:0]   cfg_bpl,
  output logic [CWN-1:0]   cfg_bpn,
  output lg_pkg::dat_t     cfg_oe0,
  output lg_pkg::dat_t     cfg_oe1,
  output lg_pkg::dat_t     cfg_msk,
  output lg_pkg::dat_t     cfg_val,
  output lg_pkg::evn_t     ctl,      // event pulses
  output logic             ctl_trg,
  output lg_pkg::evn_t     evo,
  output logic             irq
);

  // register map, byte addresses
  localparam logic [lg_pkg::BAW-1:0] A_EVN = 'h00;
  localparam logic [lg_pkg::BAW-1:0] A_TRG = 'h08;
  localparam logic [lg_pkg::BAW-1:0] A_INF = 'h10;
  localparam logic [lg_pkg::BAW-1:0] A_BDR = 'h20;
  localparam logic [lg_pkg::BAW-1:0] A_BDL = 'h24;
  localparam logic [lg_pkg::BAW-1:0] A_BPL = 'h28;
  localparam logic [lg_pkg::BAW-1:0] A_BPN = 'h2c;
  localparam logic [lg_pkg::BAW-1:0] A_SPL = 'h30;
  localparam logic [lg_pkg::BAW-1:0] A_SPN = 'h34;
  localparam logic [lg_pkg::BAW-1:0] A_OE0 = 'h40;
  localparam logic [lg_pkg::BAW-1:0] A_OE1 = 'h44;
  localparam logic [lg_pkg::BAW-1:0] A_MSK = 'h48;
  localparam logic [lg_pkg::BAW-1:0] A_VAL = 'h4c;

  logic [TN-1:0]         cfg_trg;  // trigger mask
  lg_pkg::evn_word_u     ew_wr;    // event write decode
  lg_pkg::evn_word_u     ew_rd;    // generator status word
  logic                  ack_q;
  logic [lg_pkg::BDW-1:0] rdata_q;

  assign ew_wr.raw = reg_req.wdata;

  // status as event bits
  always_comb begin
    ew_rd.raw         = '0;
    ew_rd.fld.evn.str = |sts_run;     // armed or running
    ew_rd.fld.evn.stp = ~|sts_run;    // idle
    ew_rd.fld.evn.swt = sts_run[1];   // triggered, burst active
  end

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      cfg_trg <= '0;
      cfg_inf <= 1'b0;
      cfg_bdr <= '0;
      cfg_bdl <= '0;
      cfg_bpl <= '0;
      cfg_bpn <= '0;
      cfg_oe0 <= '0;
      cfg_oe1 <= '0;
      cfg_msk <= '0;
      cfg_val <= '0;
    end else if (reg_req.wen) begin
      case (reg_req.addr)
        A_TRG: cfg_trg <= reg_req.wdata[TN-1:0];
        A_INF: cfg_inf <= reg_req.wdata[0];
        A_BDR: cfg_bdr <= reg_req.wdata[CWR-1:0];  // repeats - 1
        A_BDL: cfg_bdl <= reg_req.wdata[AW-1:0];   // data words - 1
        A_BPL: cfg_bpl <= reg_req.wdata[CWL-1:0];  // period beats - 1
        A_BPN: cfg_bpn <= reg_req.wdata[CWN-1:0];  // periods - 1
        A_OE0: cfg_oe0 <= reg_req.wdata[lg_pkg::DW-1:0];
        A_OE1: cfg_oe1 <= reg_req.wdata[lg_pkg::DW-1:0];
        A_MSK: cfg_msk <= reg_req.wdata[lg_pkg::DW-1:0];
        A_VAL: cfg_val <= reg_req.wdata[lg_pkg::DW-1:0];
        default: ;
      endcase
    end
  end

  // one cycle event pulses from a write to 0x00
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      ctl <= '0;
    end else begin
      ctl <= (reg_req.wen && reg_req.addr == A_EVN) ? ew_wr.fld.evn : '0;
    end
  end

  assign evo     = ctl;                         // copy for other generators
  assign ctl_trg = ctl.swt | (|(trg & cfg_trg)); // raw, same cycle

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) ack_q <= 1'b0;
    else        ack_q <= reg_req.wen | reg_req.ren;
  end

  always_ff @(posedge bus) begin
    if (reg_req.ren) begin
      case (reg_req.addr)
        A_EVN:   rdata_q <= ew_rd.raw;
        A_TRG:   rdata_q <= 32'(cfg_trg);
        A_INF:   rdata_q <= 32'(cfg_inf);
        A_BDR:   rdata_q <= 32'(cfg_bdr);
        A_BDL:   rdata_q <= 32'(cfg_bdl);
        A_BPL:   rdata_q <= 32'(cfg_bpl);
        A_BPN:   rdata_q <= 32'(cfg_bpn);
        A_SPL:   rdata_q <= 32'(sts_bpl);  // beat in period
        A_SPN:   rdata_q <= 32'(sts_bpn);  // periods done
        A_OE0:   rdata_q <= 32'(cfg_oe0);
        A_OE1:   rdata_q <= 32'(cfg_oe1);
        A_MSK:   rdata_q <= 32'(cfg_msk);
        A_VAL:   rdata_q <= 32'(cfg_val);
        default: rdata_q <= '0;            // unmapped
      endcase
    end
  end

  assign reg_rsp = '{ack: ack_q, rdata: rdata_q};

  // interrupt one cycle after the last period
  always_ff @(posedge bus) begin
    if (!rst_n) irq <= 1'b0;
    else        irq <= irq_src;
  end

  // every ack answers exactly one strobe of the cycle before
  a_ack_req: assert property (@(posedge bus) disable iff (!rst_n)
    reg_rsp.ack |-> $past(reg_req.wen ^ reg_req.ren));

endmodule

`default_nettype wire

// ==== lg_pkg.sv ====
// logic pattern generator shared types
// bus request/response, event and trigger bits, stream beats
// and the event register word union
`default_nettype none

package lg_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int unsigned DW  = 8;   // output data word
  localparam int unsigned BAW = 12;  // bus byte address
  localparam int unsigned BDW = 32;  // bus data

  typedef logic [DW-1:0] dat_t;

  //////////////////////////////////////////////////
  // CPU bus
  //////////////////////////////////////////////////

  typedef struct packed {
    logic           wen;    // write strobe, one cycle
    logic           ren;    // read strobe, one cycle
    logic [BAW-1:0] addr;   // byte address
    logic [BDW-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic           ack;    // one cycle after the strobe
    logic [BDW-1:0] rdata;  // valid with ack
  } bus_rsp_t;

  //////////////////////////////////////////////////
  // events and triggers
  //////////////////////////////////////////////////

  typedef struct packed {
    logic rst;  // clear counters
    logic str;  // start, arms the generator
    logic stp;  // stop, aborts and disarms
    logic swt;  // software trigger
  } evn_t;

  // event register, raw bus word or event bits
  typedef union packed {
    logic [BDW-1:0] raw;
    struct packed {
      logic [BDW-$bits(evn_t)-1:0] pad;
      evn_t                        evn;
    } fld;
  } evn_word_u;

  typedef struct packed {
    logic per;  // period start
    logic lst;  // last period ends
  } trg_t;

  //////////////////////////////////////////////////
  // output stream
  //////////////////////////////////////////////////

  typedef struct packed {
    dat_t o;  // value
    dat_t e;  // output enable
  } out_t;

  typedef struct packed {
    logic valid;
    out_t dat;
  } stm_t;

endpackage

`default_nettype wire
